// File: verilog/rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

   // major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      LOAD   = 5'd0,
      BUBBLE = 5'd2,
      OPIMM  = 5'd4,
      AUIPC  = 5'd5,
      STORE  = 5'd8,
      OPREG  = 5'd12,
      LUI    = 5'd13,
      BRANCH = 5'd24,
      JALR   = 5'd25,
      JAL    = 5'd27,
      CSRW   = 5'd28
   } opcode_t;

   // {funct7b5, funct3} for register ops, PASSB is a spare code
   typedef enum logic [3:0] {
      ADD   = 4'd0,
      SLL   = 4'd1,
      SLT   = 4'd2,
      SLTU  = 4'd3,
      XOR   = 4'd4,
      SRL   = 4'd5,
      OR    = 4'd6,
      AND   = 4'd7,
      SUB   = 4'd8,
      PASSB = 4'd9,
      SRA   = 4'd13
   } aluOp_t;

   typedef enum logic [2:0] {
      IMM_I = 3'd1,
      IMM_S = 3'd2,
      IMM_B = 3'd3,
      IMM_U = 3'd4,
      IMM_J = 3'd5,
      IMM_X = 3'd6
   } immType_t;

   // branch funct3
   typedef enum logic [2:0] {
      BEQ  = 3'd0,
      BNE  = 3'd1,
      BLT  = 3'd4,
      BGE  = 3'd5,
      BLTU = 3'd6,
      BGEU = 3'd7
   } brCond_t;

   typedef struct packed {
      opcode_t    opcode;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [2:0] funct3;
      logic       funct7b5;
   } decInst_t;

   typedef struct packed {
      logic       aSel;
      logic       bSel;
      logic       brUn;
      aluOp_t     aluSel;
      logic       instSel;
      logic [1:0] pcSel;
      logic       csrEn;
      logic       csrSel;
      logic       memRw;
      logic [1:0] sSel;
   } exCtrl_t;

   typedef struct packed {
      logic [2:0] ldSel;
      logic [1:0] wbSel;
      logic       regWrEn;
      logic [1:0] mmapDmemSel;
   } wbCtrl_t;

   // addi x0, x0, 0
   localparam logic [31:0] NOP_WORD = 32'h00000013;

   localparam logic [1:0] PC_SEQ  = 2'd0;
   localparam logic [1:0] PC_ALU  = 2'd1;
   localparam logic [1:0] PC_HOLD = 2'd2;

   localparam logic [1:0] ST_NONE = 2'd3;
   localparam logic [2:0] LD_NONE = 3'd7;

   localparam logic [1:0] WB_MEM = 2'd0;
   localparam logic [1:0] WB_ALU = 2'd1;
   localparam logic [1:0] WB_PC4 = 2'd2;

   // load data source mux
   localparam logic [1:0] MDS_DMEM   = 2'd0;
   localparam logic [1:0] MDS_RXDATA = 2'd1;
   localparam logic [1:0] MDS_STATUS = 2'd2;

endpackage

`default_nettype wire

// File: verilog/mmioPkg.sv
`default_nettype none

package mmioPkg;

   // UART register map
   localparam logic [31:0] UART_CTRL = 32'h8000_0000;
   localparam logic [31:0] UART_RX   = 32'h8000_0004;
   localparam logic [31:0] UART_TX   = 32'h8000_0008;
   localparam logic [31:0] UART_CC   = 32'h8000_0010;
   localparam logic [31:0] UART_IC   = 32'h8000_0014;
   localparam logic [31:0] UART_RST  = 32'h8000_0018;

   typedef enum logic [2:0] {
      RGN_DMEM = 3'd0,
      RGN_CTRL = 3'd1,
      RGN_RX   = 3'd2,
      RGN_TX   = 3'd3,
      RGN_CC   = 3'd4,
      RGN_IC   = 3'd5,
      RGN_RST  = 3'd6,
      RGN_NONE = 3'd7
   } memRegion_t;

   typedef enum logic [2:0] {
      CTRL = 3'd0,
      RX   = 3'd1,
      TX   = 3'd2,
      CC   = 3'd3,
      IC   = 3'd4,
      RST  = 3'd5,
      NONE = 3'd7
   } mmapSel_t;

endpackage

`default_nettype wire

// File: verilog/instPipe.sv
`timescale 1ns/10ps
`default_nettype none

module instPipe (
   input  logic                clk,
   input  logic                rst,
   input  logic [31:0]         inst,
   output rvCtrlPkg::decInst_t decDec,
   output rvCtrlPkg::decInst_t decEx,
   output rvCtrlPkg::decInst_t decWb,
   output rvCtrlPkg::immType_t immSel
);
   import rvCtrlPkg::*;

   // pull the control fields out of a raw word
   function automatic decInst_t decode(input logic [31:0] word);
      decInst_t d;
      d.rd       = word[11:7];
      d.rs1      = word[19:15];
      d.rs2      = word[24:20];
      d.funct3   = word[14:12];
      d.funct7b5 = word[30];
      case (word[6:2])
         LOAD, STORE, BRANCH, JALR, JAL, OPREG, OPIMM, AUIPC, LUI, CSRW:
            d.opcode = opcode_t'(word[6:2]);
         default:
            d.opcode = BUBBLE;
      endcase
      return d;
   endfunction

   assign decDec = decode(inst);

   // immediate format for the decode-stage generator
   always_comb begin
      case (decDec.opcode)
         LOAD, JALR, OPIMM: immSel = IMM_I;
         STORE:             immSel = IMM_S;
         BRANCH:            immSel = IMM_B;
         JAL:               immSel = IMM_J;
         AUIPC, LUI:        immSel = IMM_U;
         default:           immSel = IMM_X;
      endcase
   end

   // two stage registers, both start out holding the nop
   always_ff @(posedge clk) begin
      if (rst) begin
         decEx <= decode(NOP_WORD);
         decWb <= decode(NOP_WORD);
      end else begin
         decEx <= decDec;
         decWb <= decEx;
      end
   end

endmodule

`default_nettype wire

// File: verilog/fwdUnit.sv
`timescale 1ns/10ps
`default_nettype none

module fwdUnit (
   input  rvCtrlPkg::decInst_t decDec,
   input  rvCtrlPkg::decInst_t decEx,
   input  rvCtrlPkg::decInst_t decWb,
   output logic                fa1,
   output logic                fb1,
   output logic                fa2,
   output logic                fb2
);
   import rvCtrlPkg::*;

   function automatic logic writesRd(input opcode_t op);
      return (op != BRANCH) && (op != STORE) && (op != BUBBLE);
   endfunction

   function automatic logic readsRs1(input opcode_t op);
      return (op != LUI) && (op != AUIPC) && (op != JAL) && (op != BUBBLE);
   endfunction

   // rs2 users are a subset of the rs1 users
   function automatic logic readsRs2(input opcode_t op);
      return readsRs1(op) && (op != JALR) && (op != LOAD) &&
             (op != OPIMM) && (op != CSRW);
   endfunction

   // csrw compares rs1 even when it names x0
   function automatic logic fwdRs1(input decInst_t cons, input decInst_t prod);
      logic nonZero;
      nonZero = (prod.rd != 5'd0) && (cons.rs1 != 5'd0);
      return writesRd(prod.opcode) && readsRs1(cons.opcode) &&
             (prod.rd == cons.rs1) && (nonZero || (cons.opcode == CSRW));
   endfunction

   function automatic logic fwdRs2(input decInst_t cons, input decInst_t prod);
      logic nonZero;
      nonZero = (prod.rd != 5'd0) && (cons.rs2 != 5'd0);
      return writesRd(prod.opcode) && readsRs2(cons.opcode) &&
             (prod.rd == cons.rs2) && nonZero;
   endfunction

   // writeback result into the word being decoded
   assign fa1 = fwdRs1(decDec, decWb);
   assign fb1 = fwdRs2(decDec, decWb);

   // writeback result into the execute operands
   assign fa2 = fwdRs1(decEx, decWb);
   assign fb2 = fwdRs2(decEx, decWb);

endmodule

`default_nettype wire

// File: verilog/exCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module exCtrl (
   input  rvCtrlPkg::decInst_t decEx,
   input  logic [31:0]         aluOut,
   input  logic                brEq,
   input  logic                brLt,
   output rvCtrlPkg::exCtrl_t  exCtl,
   output mmioPkg::mmapSel_t   mmapSel,
   output logic                dataInValid,
   output logic                dataOutReady,
   output mmioPkg::memRegion_t exRegion
);
   import rvCtrlPkg::*;
   import mmioPkg::*;

   logic memAccess;
   logic uartHit;
   logic taken;

   assign memAccess = (decEx.opcode == LOAD) || (decEx.opcode == STORE);

   // data memory lives at 0x1xxx_xxxx and 0x3xxx_xxxx
   always_comb begin
      if (aluOut[31:28] == 4'b0001 || aluOut[31:28] == 4'b0011) begin
         exRegion = RGN_DMEM;
      end else begin
         case (aluOut)
            UART_CTRL: exRegion = RGN_CTRL;
            UART_RX:   exRegion = RGN_RX;
            UART_TX:   exRegion = RGN_TX;
            UART_CC:   exRegion = RGN_CC;
            UART_IC:   exRegion = RGN_IC;
            UART_RST:  exRegion = RGN_RST;
            default:   exRegion = RGN_NONE;
         endcase
      end
   end

   assign uartHit = (exRegion != RGN_DMEM) && (exRegion != RGN_NONE);

   // comparator flags against funct3
   always_comb begin
      case (brCond_t'(decEx.funct3))
         BEQ:       taken = brEq;
         BNE:       taken = !brEq;
         BLT, BLTU: taken = brLt;
         BGE, BGEU: taken = !brLt;
         default:   taken = 1'b0;
      endcase
   end

   always_comb begin
      exCtl = '{aSel: 1'b0, bSel: 1'b1, brUn: 1'b0, aluSel: ADD,
                instSel: 1'b0, pcSel: PC_SEQ, csrEn: 1'b0, csrSel: 1'b0,
                memRw: 1'b0, sSel: ST_NONE};
      case (decEx.opcode)
         LOAD: begin
            exCtl.memRw = !uartHit;
         end
         STORE: begin
            exCtl.memRw = !uartHit;
            exCtl.sSel  = decEx.funct3[1:0];
         end
         BRANCH: begin
            // target is pc + imm, the fetched word is squashed
            exCtl.aSel    = 1'b1;
            exCtl.brUn    = (decEx.funct3[2:1] == 2'b11);
            exCtl.instSel = 1'b1;
            exCtl.pcSel   = taken ? PC_ALU : PC_HOLD;
         end
         JALR: begin
            exCtl.instSel = 1'b1;
            exCtl.pcSel   = PC_ALU;
         end
         JAL: begin
            exCtl.aSel    = 1'b1;
            exCtl.instSel = 1'b1;
            exCtl.pcSel   = PC_ALU;
         end
         OPREG: begin
            exCtl.bSel   = 1'b0;
            exCtl.aluSel = aluOp_t'({decEx.funct7b5, decEx.funct3});
         end
         OPIMM: begin
            // bit 30 is immediate data except on shifts
            if (decEx.funct3[1:0] == 2'b01) begin
               exCtl.aluSel = aluOp_t'({decEx.funct7b5, decEx.funct3});
            end else begin
               exCtl.aluSel = aluOp_t'({1'b0, decEx.funct3});
            end
         end
         AUIPC: begin
            exCtl.aSel = 1'b1;
         end
         LUI: begin
            exCtl.aluSel = PASSB;
         end
         CSRW: begin
            exCtl.bSel   = 1'b0;
            exCtl.aluSel = PASSB;
            exCtl.csrEn  = 1'b1;
            exCtl.csrSel = decEx.funct3[2];
         end
         default: begin
            exCtl.aluSel = PASSB;
            exCtl.pcSel  = PC_HOLD;
         end
      endcase
   end

   // UART register select, only for loads and stores
   always_comb begin
      mmapSel = NONE;
      if (memAccess) begin
         case (exRegion)
            RGN_CTRL: mmapSel = CTRL;
            RGN_RX:   mmapSel = RX;
            RGN_TX:   mmapSel = TX;
            RGN_CC:   mmapSel = CC;
            RGN_IC:   mmapSel = IC;
            RGN_RST:  mmapSel = RST;
            default:  mmapSel = NONE;
         endcase
      end
   end

   assign dataOutReady = (decEx.opcode == LOAD) && (exRegion == RGN_RX);
   assign dataInValid  = (decEx.opcode == STORE) && (exRegion == RGN_TX);

endmodule

`default_nettype wire

// File: verilog/wbCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module wbCtrl (
   input  logic                clk,
   input  logic                rst,
   input  rvCtrlPkg::decInst_t decWb,
   input  mmioPkg::memRegion_t exRegion,
   output rvCtrlPkg::wbCtrl_t  wbCtl
);
   import rvCtrlPkg::*;
   import mmioPkg::*;

   memRegion_t wbRegion;
   logic       rdLive;
   logic       loadOk;

   // region follows its instruction into writeback
   always_ff @(posedge clk) begin
      if (rst) begin
         wbRegion <= RGN_NONE;
      end else begin
         wbRegion <= exRegion;
      end
   end

   // x0 is never written, so the reset bubble stays quiet
   assign rdLive = (decWb.rd != 5'd0);

   // readable sources: data memory, rx data and the status registers
   assign loadOk = (wbRegion == RGN_DMEM) || (wbRegion == RGN_RX) ||
                   (wbRegion == RGN_CTRL) || (wbRegion == RGN_CC) ||
                   (wbRegion == RGN_IC);

   always_comb begin
      wbCtl = '{ldSel: LD_NONE, wbSel: WB_MEM, regWrEn: 1'b0,
                mmapDmemSel: MDS_DMEM};
      case (decWb.opcode)
         LOAD: begin
            wbCtl.ldSel   = decWb.funct3;
            wbCtl.regWrEn = loadOk && rdLive;
            case (wbRegion)
               RGN_RX:                   wbCtl.mmapDmemSel = MDS_RXDATA;
               RGN_CTRL, RGN_CC, RGN_IC: wbCtl.mmapDmemSel = MDS_STATUS;
               default:                  wbCtl.mmapDmemSel = MDS_DMEM;
            endcase
         end
         JAL, JALR: begin
            wbCtl.wbSel   = WB_PC4;
            wbCtl.regWrEn = rdLive;
         end
         OPREG, OPIMM, AUIPC, LUI: begin
            wbCtl.wbSel   = WB_ALU;
            wbCtl.regWrEn = rdLive;
         end
         default: begin
            wbCtl.regWrEn = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/pipeCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module pipeCtrl (
   input  logic                clk,
   input  logic                rst,
   input  logic [31:0]         inst,
   input  logic [31:0]         aluOut,
   input  logic                brEq,
   input  logic                brLt,
   output rvCtrlPkg::immType_t immSel,
   output rvCtrlPkg::exCtrl_t  exCtl,
   output mmioPkg::mmapSel_t   mmapSel,
   output logic                dataInValid,
   output logic                dataOutReady,
   output rvCtrlPkg::wbCtrl_t  wbCtl,
   output logic                fa1,
   output logic                fb1,
   output logic                fa2,
   output logic                fb2
);
   import rvCtrlPkg::*;
   import mmioPkg::*;

   // decoded word at each stage
   decInst_t   decDec;
   decInst_t   decEx;
   decInst_t   decWb;
   memRegion_t exRegion;

   instPipe instPipe_i (
      .clk    (clk),
      .rst    (rst),
      .inst   (inst),
      .decDec (decDec),
      .decEx  (decEx),
      .decWb  (decWb),
      .immSel (immSel)
   );

   fwdUnit fwdUnit_i (
      .decDec (decDec),
      .decEx  (decEx),
      .decWb  (decWb),
      .fa1    (fa1),
      .fb1    (fb1),
      .fa2    (fa2),
      .fb2    (fb2)
   );

   exCtrl exCtrl_i (
      .decEx        (decEx),
      .aluOut       (aluOut),
      .brEq         (brEq),
      .brLt         (brLt),
      .exCtl        (exCtl),
      .mmapSel      (mmapSel),
      .dataInValid  (dataInValid),
      .dataOutReady (dataOutReady),
      .exRegion     (exRegion)
   );

   wbCtrl wbCtrl_i (
      .clk      (clk),
      .rst      (rst),
      .decWb    (decWb),
      .exRegion (exRegion),
      .wbCtl    (wbCtl)
   );

endmodule

`default_nettype wire

// File: verif/pipeCtrlTb.sv
`timescale 1ns/10ps
`default_nettype none

module pipeCtrlTb;
   import rvCtrlPkg::*;
   import mmioPkg::*;

   // major opcodes, bits 6:0
   localparam int OP_LD    = 7'h03;
   localparam int OP_ST    = 7'h23;
   localparam int OP_BR    = 7'h63;
   localparam int OP_JALR  = 7'h67;
   localparam int OP_JAL   = 7'h6f;
   localparam int OP_R     = 7'h33;
   localparam int OP_I     = 7'h13;
   localparam int OP_AUIPC = 7'h17;
   localparam int OP_LUI   = 7'h37;
   localparam int OP_CSR   = 7'h73;

   typedef struct packed {
      logic [31:0] inst;
      logic [31:0] alu;
      logic        eq;
      logic        lt;
      logic        chk;
      immType_t    imm;
      exCtrl_t     ex;
      mmapSel_t    mm;
      logic        div;
      logic        dor;
      wbCtrl_t     wb;
   } stimRow_t;

   logic        clk;
   logic        rst;
   logic [31:0] inst;
   logic [31:0] aluOut;
   logic        brEq;
   logic        brLt;
   immType_t    immSel;
   exCtrl_t     exCtl;
   mmapSel_t    mmapSel;
   logic        dataInValid;
   logic        dataOutReady;
   wbCtrl_t     wbCtl;
   logic        fa1;
   logic        fb1;
   logic        fa2;
   logic        fb2;

   stimRow_t rows[$];
   int       nRows = 0;
   int       errors = 0;
   integer   seed = 32'h852d;

   pipeCtrl pipeCtrl_i (
      .clk          (clk),
      .rst          (rst),
      .inst         (inst),
      .aluOut       (aluOut),
      .brEq         (brEq),
      .brLt         (brLt),
      .immSel       (immSel),
      .exCtl        (exCtl),
      .mmapSel      (mmapSel),
      .dataInValid  (dataInValid),
      .dataOutReady (dataOutReady),
      .wbCtl        (wbCtl),
      .fa1          (fa1),
      .fb1          (fb1),
      .fa2          (fa2),
      .fb2          (fb2)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] enc(input int op, input int rd, input int f3,
                                       input int rs1, input int rs2, input int f7);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction

   // reference forwarding rules
   function automatic logic knownOp(input logic [31:0] w);
      case (int'(w[6:0]))
         OP_LD, OP_ST, OP_BR, OP_JALR, OP_JAL, OP_R, OP_I, OP_AUIPC, OP_LUI, OP_CSR:
            return 1'b1;
         default:
            return 1'b0;
      endcase
   endfunction

   function automatic logic writesDest(input logic [31:0] w);
      return knownOp(w) && int'(w[6:0]) != OP_BR && int'(w[6:0]) != OP_ST;
   endfunction

   function automatic logic readsSrc1(input logic [31:0] w);
      return knownOp(w) && int'(w[6:0]) != OP_LUI && int'(w[6:0]) != OP_AUIPC &&
             int'(w[6:0]) != OP_JAL;
   endfunction

   function automatic logic readsSrc2(input logic [31:0] w);
      int op;
      op = int'(w[6:0]);
      return readsSrc1(w) && op != OP_JALR && op != OP_LD && op != OP_I && op != OP_CSR;
   endfunction

   function automatic logic expFwd1(input logic [31:0] cons, input logic [31:0] prod);
      logic zeroOk;
      zeroOk = (prod[11:7] != 5'd0 && cons[19:15] != 5'd0) || int'(cons[6:0]) == OP_CSR;
      return writesDest(prod) && readsSrc1(cons) && prod[11:7] == cons[19:15] && zeroOk;
   endfunction

   function automatic logic expFwd2(input logic [31:0] cons, input logic [31:0] prod);
      return writesDest(prod) && readsSrc2(cons) && prod[11:7] == cons[24:20] &&
             prod[11:7] != 5'd0 && cons[24:20] != 5'd0;
   endfunction

   function automatic logic [31:0] instAt(input int idx);
      if (idx >= 0 && idx < rows.size()) begin
         return rows[idx].inst;
      end
      return NOP_WORD;
   endfunction

   // expected values for a plain alu instruction
   function automatic exCtrl_t exBase();
      exCtrl_t e;
      e.aSel    = 1'b0;
      e.bSel    = 1'b1;
      e.brUn    = 1'b0;
      e.aluSel  = ADD;
      e.instSel = 1'b0;
      e.pcSel   = PC_SEQ;
      e.csrEn   = 1'b0;
      e.csrSel  = 1'b0;
      e.memRw   = 1'b0;
      e.sSel    = ST_NONE;
      return e;
   endfunction

   function automatic wbCtrl_t wbv(input int ld, input int wbS, input int we, input int mds);
      wbCtrl_t w;
      w.ldSel       = ld[2:0];
      w.wbSel       = wbS[1:0];
      w.regWrEn     = we[0];
      w.mmapDmemSel = mds[1:0];
      return w;
   endfunction

   task automatic putRow(input logic [31:0] w, input logic [31:0] alu, input int eq,
                         input int lt, input int chk, input immType_t imm,
                         input exCtrl_t ex, input mmapSel_t mm, input int div,
                         input int dor, input wbCtrl_t wb);
      stimRow_t r;
      r.inst = w;
      r.alu  = alu;
      r.eq   = eq[0];
      r.lt   = lt[0];
      r.chk  = chk[0];
      r.imm  = imm;
      r.ex   = ex;
      r.mm   = mm;
      r.div  = div[0];
      r.dor  = dor[0];
      r.wb   = wb;
      rows.push_back(r);
   endtask

   task automatic opRow(input logic [31:0] w, input immType_t imm, input aluOp_t op,
                        input int aS, input int bS, input int we);
      exCtrl_t e;
      e = exBase();
      e.aSel   = aS[0];
      e.bSel   = bS[0];
      e.aluSel = op;
      putRow(w, 0, 0, 0, 1, imm, e, NONE, 0, 0, wbv(7, 1, we, 0));
   endtask

   task automatic jmpRow(input logic [31:0] w, input immType_t imm, input int aS);
      exCtrl_t e;
      e = exBase();
      e.aSel    = aS[0];
      e.instSel = 1'b1;
      e.pcSel   = PC_ALU;
      putRow(w, 0, 0, 0, 1, imm, e, NONE, 0, 0, wbv(7, 2, 1, 0));
   endtask

   task automatic csrRow(input logic [31:0] w, input int sel);
      exCtrl_t e;
      e = exBase();
      e.bSel   = 1'b0;
      e.aluSel = PASSB;
      e.csrEn  = 1'b1;
      e.csrSel = sel[0];
      putRow(w, 0, 0, 0, 1, IMM_X, e, NONE, 0, 0, wbv(7, 0, 0, 0));
   endtask

   task automatic brRow(input int f3, input int eq, input int lt, input int pc, input int un);
      exCtrl_t e;
      e = exBase();
      e.aSel    = 1'b1;
      e.brUn    = un[0];
      e.instSel = 1'b1;
      e.pcSel   = pc[1:0];
      putRow(enc(OP_BR, 8, f3, 1, 2, 0), 0, eq, lt, 1, IMM_B, e, NONE, 0, 0, wbv(7, 0, 0, 0));
   endtask

   task automatic ldRow(input int f3, input int rd, input logic [31:0] addr,
                        input mmapSel_t mm, input int mem, input int dor,
                        input int we, input int mds);
      exCtrl_t e;
      e = exBase();
      e.memRw = mem[0];
      putRow(enc(OP_LD, rd, f3, 1, 0, 0), addr, 0, 0, 1, IMM_I, e, mm, 0, dor,
             wbv(f3, 0, we, mds));
   endtask

   task automatic stRow(input int f3, input logic [31:0] addr, input mmapSel_t mm,
                        input int mem, input int div);
      exCtrl_t e;
      e = exBase();
      e.memRw = mem[0];
      e.sSel  = f3[1:0];
      putRow(enc(OP_ST, 4, f3, 1, 2, 0), addr, 0, 0, 1, IMM_S, e, mm, div, 0,
             wbv(7, 0, 0, 0));
   endtask

   task automatic buildTable();
      // dependent chain, then x0 suppression
      opRow(enc(OP_R, 1, 0, 2, 3, 0), IMM_X, ADD, 0, 0, 1);
      opRow(enc(OP_R, 4, 0, 1, 5, 7'h20), IMM_X, SUB, 0, 0, 1);
      opRow(enc(OP_R, 6, 5, 4, 1, 7'h20), IMM_X, SRA, 0, 0, 1);
      opRow(enc(OP_R, 0, 7, 1, 2, 0), IMM_X, AND, 0, 0, 0);
      opRow(enc(OP_R, 3, 6, 0, 0, 0), IMM_X, OR, 0, 0, 1);
      // bit 30 only matters for immediate shifts
      opRow(enc(OP_I, 9, 0, 3, 0, 7'h20), IMM_I, ADD, 0, 1, 1);
      opRow(enc(OP_I, 10, 5, 9, 0, 7'h20), IMM_I, SRA, 0, 1, 1);
      opRow(enc(OP_I, 11, 1, 10, 0, 0), IMM_I, SLL, 0, 1, 1);
      opRow(enc(OP_I, 11, 3, 10, 0, 7'h20), IMM_I, SLTU, 0, 1, 1);
      opRow(enc(OP_LUI, 12, 0, 0, 0, 0), IMM_U, PASSB, 0, 1, 1);
      opRow(enc(OP_AUIPC, 13, 0, 0, 0, 0), IMM_U, ADD, 1, 1, 1);
      jmpRow(enc(OP_JAL, 1, 0, 0, 0, 0), IMM_J, 1);
      jmpRow(enc(OP_JALR, 5, 0, 1, 0, 0), IMM_I, 0);
      // nops write x0, which csrw with rs1 = x0 still picks up
      opRow(NOP_WORD, IMM_I, ADD, 0, 1, 0);
      opRow(NOP_WORD, IMM_I, ADD, 0, 1, 0);
      csrRow(enc(OP_CSR, 0, 1, 0, 0, 0), 0);
      csrRow(enc(OP_CSR, 0, 5, 2, 0, 0), 1);
      // f3, brEq, brLt, pcSel, brUn
      brRow(0, 1, 0, 1, 0);
      brRow(0, 0, 1, 2, 0);
      brRow(1, 0, 0, 1, 0);
      brRow(1, 1, 0, 2, 0);
      brRow(4, 0, 1, 1, 0);
      brRow(4, 0, 0, 2, 0);
      brRow(5, 0, 1, 2, 0);
      brRow(5, 0, 0, 1, 0);
      brRow(6, 1, 0, 2, 1);
      brRow(6, 0, 1, 1, 1);
      brRow(7, 1, 0, 1, 1);
      brRow(7, 0, 1, 2, 1);
      // f3, rd, address, mmapSel, memRw, dataOutReady, regWrEn, mmapDmemSel
      ldRow(2, 14, 32'h1000_0040, NONE, 1, 0, 1, MDS_DMEM);
      ldRow(2, 14, UART_CTRL, CTRL, 0, 0, 1, MDS_STATUS);
      ldRow(2, 15, UART_RX, RX, 0, 1, 1, MDS_RXDATA);
      ldRow(2, 16, UART_TX, TX, 0, 0, 0, MDS_DMEM);
      ldRow(0, 17, UART_CC, CC, 0, 0, 1, MDS_STATUS);
      ldRow(4, 18, UART_IC, IC, 0, 0, 1, MDS_STATUS);
      ldRow(2, 19, UART_RST, RST, 0, 0, 0, MDS_DMEM);
      ldRow(2, 20, 32'h4000_0000, NONE, 1, 0, 0, MDS_DMEM);
      // f3, address, mmapSel, memRw, dataInValid
      stRow(2, 32'h3000_0100, NONE, 1, 0);
      stRow(2, UART_CTRL, CTRL, 0, 0);
      stRow(0, UART_RX, RX, 0, 0);
      stRow(2, UART_TX, TX, 0, 1);
      stRow(1, UART_CC, CC, 0, 0);
      stRow(0, UART_IC, IC, 0, 0);
      stRow(2, UART_RST, RST, 0, 0);
      stRow(2, 32'h0000_0200, NONE, 1, 0);
   endtask

   // small register range so that hits and x0 cases are common
   task automatic addRandomRows();
      int sel;
      int rd;
      int rs1;
      int rs2;
      logic [31:0] w;
      for (int k = 0; k < 40; k++) begin
         sel = $unsigned($random(seed)) % 3;
         rd  = $random(seed) & 3;
         rs1 = $random(seed) & 3;
         rs2 = $random(seed) & 3;
         case (sel)
            0:       w = enc(OP_R, rd, 0, rs1, rs2, 0);
            1:       w = enc(OP_LD, rd, 2, rs1, rs2, 0);
            default: w = enc(OP_ST, rd, 2, rs1, rs2, 0);
         endcase
         putRow(w, 0, 0, 0, 0, IMM_X, exBase(), NONE, 0, 0, wbv(7, 0, 0, 0));
      end
   endtask

   task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         errors++;
         $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
      end
   endtask

   task automatic checkQuiet();
      checkVal("regWrEn", 0, 32'(wbCtl.regWrEn));
      checkVal("memRw", 0, 32'(exCtl.memRw));
      checkVal("csrEn", 0, 32'(exCtl.csrEn));
      checkVal("dataInValid", 0, 32'(dataInValid));
      checkVal("dataOutReady", 0, 32'(dataOutReady));
   endtask

   initial begin
      wait (nRows > 0);
      #((nRows + 20) * 40);
      errors++;
      $display("timeout: the test sequence did not complete in time");
      $display("errors: %0d", errors);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      rst    = 1'b1;
      // a live rx load sits at the input while the stages are held in reset
      inst   = enc(OP_LD, 5, 2, 1, 0, 0);
      aluOut = UART_RX;
      brEq   = 1'b0;
      brLt   = 1'b0;
      buildTable();
      addRandomRows();
      nRows = rows.size();

      repeat (10) begin
         @(posedge clk);
         @(negedge clk);
         checkQuiet();
      end

      // row i in decode, row i-1 in execute, row i-2 in writeback
      for (int i = 0; i < nRows + 2; i++) begin
         @(posedge clk);
         #2;
         rst  = 1'b0;
         inst = instAt(i);
         if (i >= 1 && i - 1 < nRows) begin
            aluOut = rows[i - 1].alu;
            brEq   = rows[i - 1].eq;
            brLt   = rows[i - 1].lt;
         end else begin
            aluOut = 32'd0;
            brEq   = 1'b0;
            brLt   = 1'b0;
         end
         @(negedge clk);
         if (i == 0) begin
            checkQuiet();
         end
         if (i < nRows) begin
            if (rows[i].chk) begin
               checkVal("immSel", 32'(rows[i].imm), 32'(immSel));
            end
            checkVal("fa1", 32'(expFwd1(instAt(i), instAt(i - 2))), 32'(fa1));
            checkVal("fb1", 32'(expFwd2(instAt(i), instAt(i - 2))), 32'(fb1));
         end
         if (i >= 1 && i - 1 < nRows) begin
            checkVal("fa2", 32'(expFwd1(instAt(i - 1), instAt(i - 2))), 32'(fa2));
            checkVal("fb2", 32'(expFwd2(instAt(i - 1), instAt(i - 2))), 32'(fb2));
            if (rows[i - 1].chk) begin
               checkVal("exCtl", 32'(rows[i - 1].ex), 32'(exCtl));
               checkVal("mmapSel", 32'(rows[i - 1].mm), 32'(mmapSel));
               checkVal("dataInValid", 32'(rows[i - 1].div), 32'(dataInValid));
               checkVal("dataOutReady", 32'(rows[i - 1].dor), 32'(dataOutReady));
            end
         end
         if (i >= 2 && rows[i - 2].chk) begin
            checkVal("wbCtl", 32'(rows[i - 2].wb), 32'(wbCtl));
         end
      end

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
verilog/rvCtrlPkg.sv
verilog/mmioPkg.sv
verilog/instPipe.sv
verilog/fwdUnit.sv
verilog/exCtrl.sv
verilog/wbCtrl.sv
verilog/pipeCtrl.sv
verif/pipeCtrlTb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
   -f files.f --top-module pipeCtrlTb -o pipeCtrlSim

out=$(./obj_dir/pipeCtrlSim)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -qx "PASS: all tests"
